/* rtl/cam_array_pkg.sv */
// CAM array package: entry geometry and the data, match and address types
package cam_array_pkg;

   //--------------------------------------------------------------------------
   // Geometry
   //--------------------------------------------------------------------------

   // Bits per entry and per search key
   localparam int unsigned CAM_WIDTH  = 16;

   // Number of entries, one match bit each
   localparam int unsigned CAM_DEPTH  = 16;

   // Entry address width
   localparam int unsigned CAM_ADDR_W = $clog2(CAM_DEPTH);

   //--------------------------------------------------------------------------
   // Types
   //--------------------------------------------------------------------------

   // One stored word or one search key
   typedef logic [CAM_WIDTH-1:0]  cam_data_t;

   // Match vector, bit i set when entry i equals the key
   typedef logic [CAM_DEPTH-1:0]  cam_match_t;

   // Entry index
   typedef logic [CAM_ADDR_W-1:0] cam_addr_t;

endpackage

/* rtl/cam_mbist_pkg.sv */
// CAM BIST package: controller state encoding, data background and march step counts
package cam_mbist_pkg;

   // Miss-step count follows the entry width
   import cam_array_pkg::*;

   //--------------------------------------------------------------------------
   // Controller states
   //--------------------------------------------------------------------------

   // NEXT_BG issues the last miss search and advances the background
   typedef enum logic [2:0] {
      IDLE      = 3'd0,
      WRITE     = 3'd1,
      SRCH_HIT  = 3'd2,
      SRCH_MISS = 3'd3,
      NEXT_BG   = 3'd4,
      DRAIN     = 3'd5
   } bist_state_e;

   //--------------------------------------------------------------------------
   // March parameters
   //--------------------------------------------------------------------------

   // Base pattern, the second background is its complement
   localparam cam_data_t   BIST_BACKGROUND   = 16'h5A3C;

   // Pattern and complement
   localparam int unsigned BIST_NUM_BG       = 2;
   localparam int unsigned BIST_BG_W         = $clog2(BIST_NUM_BG);

   // One miss search per key bit
   localparam int unsigned BIST_MISS_STEPS   = CAM_WIDTH;
   localparam int unsigned BIST_STEP_W       = $clog2(BIST_MISS_STEPS);

   // Cycles after the last search until the result is checked
   localparam int unsigned BIST_DRAIN_CYCLES = 2;
   localparam int unsigned BIST_DRAIN_W      = $clog2(BIST_DRAIN_CYCLES);

endpackage

/* rtl/cam_bist_if.sv */
// BIST command interface from the march controller to the CAM input handler
`timescale 1ns/100ps

interface cam_bist_if
   import cam_array_pkg::*;
();

   // BIST owns the array
   logic      busy;

   // Write command and its entry
   logic      wr_en;
   cam_addr_t wr_addr;

   // Background select, high for the complement
   logic      data_inv;

   // Search command with generated compare data
   logic      srch_en;
   logic      cm_mode;

   // Mask control for the miss searches
   logic      cd_mask_enable;
   logic      rotate_mask;

   //--------------------------------------------------------------------------
   // Views
   //--------------------------------------------------------------------------

   modport ctrl (
      output busy, wr_en, wr_addr, data_inv,
      output srch_en, cm_mode, cd_mask_enable, rotate_mask
   );

   modport handler (
      input  busy, wr_en, wr_addr, data_inv,
      input  srch_en, cm_mode, cd_mask_enable, rotate_mask
   );

endinterface

/* rtl/cam_mbist_ctrl.sv */
// CAM BIST march controller: sequences writes, hit and miss searches per background
`timescale 1ns/100ps

module cam_mbist_ctrl
   import cam_array_pkg::*;
   import cam_mbist_pkg::*;
(
   input  logic        bist_clk,
   input  logic        rst_b,
   // Start handshake
   input  logic        bist_start_valid,
   output logic        bist_start_ready,
   output logic        bist_done,
   // Commands towards the input handler
   cam_bist_if.ctrl    bist,
   // Functional port gate
   output logic        func_ready,
   // Checker qualification
   output logic        chk_en,
   output logic        exp_hit,
   output logic        chk_clear
);

   bist_state_e             state_q;
   bist_state_e             state_d;
   cam_addr_t               entry_cnt;
   logic [BIST_STEP_W-1:0]  miss_cnt;
   logic [BIST_BG_W-1:0]    bg_cnt;
   logic [BIST_DRAIN_W-1:0] drain_cnt;
   logic                    start_hs;
   logic                    entry_last;
   logic                    miss_last;
   logic                    bg_last;
   logic                    drain_last;

   //--------------------------------------------------------------------------
   // Handshake and terminal counts
   //--------------------------------------------------------------------------

   assign bist_start_ready = (state_q == IDLE);
   assign start_hs         = bist_start_valid & bist_start_ready;

   // Start also clears the checker
   assign chk_clear        = start_hs;

   assign entry_last = (entry_cnt == cam_addr_t'(CAM_DEPTH - 1));
   // Last step is issued from NEXT_BG
   assign miss_last  = (miss_cnt == BIST_STEP_W'(BIST_MISS_STEPS - 2));
   assign bg_last    = (bg_cnt == BIST_BG_W'(BIST_NUM_BG - 1));
   assign drain_last = (drain_cnt == BIST_DRAIN_W'(BIST_DRAIN_CYCLES - 1));

   //--------------------------------------------------------------------------
   // Next state
   //--------------------------------------------------------------------------

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:      if (start_hs) state_d = WRITE;
         WRITE:     if (entry_last) state_d = SRCH_HIT;
         SRCH_HIT:  state_d = SRCH_MISS;
         SRCH_MISS: if (miss_last) state_d = NEXT_BG;
         NEXT_BG:   state_d = bg_last ? DRAIN : WRITE;
         DRAIN:     if (drain_last) state_d = IDLE;
         default:   state_d = IDLE;
      endcase
   end

   //--------------------------------------------------------------------------
   // State and counters
   //--------------------------------------------------------------------------

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         state_q   <= IDLE;
         entry_cnt <= '0;
         miss_cnt  <= '0;
         bg_cnt    <= '0;
         drain_cnt <= '0;
      end else begin
         state_q <= state_d;
         if (start_hs) begin
            entry_cnt <= '0;
            miss_cnt  <= '0;
            bg_cnt    <= '0;
            drain_cnt <= '0;
         end else begin
            // One entry per write cycle, wraps for the next background
            if (state_q == WRITE) begin
               entry_cnt <= entry_last ? '0 : entry_cnt + 1'b1;
            end
            if (state_q == SRCH_MISS) begin
               miss_cnt <= miss_last ? '0 : miss_cnt + 1'b1;
            end
            if (state_q == NEXT_BG) begin
               bg_cnt <= bg_last ? '0 : bg_cnt + 1'b1;
            end
            if (state_q == DRAIN) begin
               drain_cnt <= drain_last ? '0 : drain_cnt + 1'b1;
            end
         end
      end
   end

   //--------------------------------------------------------------------------
   // Command decode
   //--------------------------------------------------------------------------

   assign bist.busy     = (state_q != IDLE);
   assign bist.wr_en    = (state_q == WRITE);
   assign bist.wr_addr  = entry_cnt;
   assign bist.data_inv = bg_cnt[0];

   // Every search uses generated compare data
   assign bist.srch_en  = (state_q == SRCH_HIT) | (state_q == SRCH_MISS) | (state_q == NEXT_BG);
   assign bist.cm_mode  = bist.srch_en;

   // Miss searches flip one bit, then move the mask on
   assign bist.cd_mask_enable = (state_q == SRCH_MISS) | (state_q == NEXT_BG);
   assign bist.rotate_mask    = bist.cd_mask_enable;

   assign chk_en     = bist.srch_en;
   assign exp_hit    = (state_q == SRCH_HIT);
   assign func_ready = ~bist.busy;

   // Last drain cycle, the final result has been checked by now
   assign bist_done  = (state_q == DRAIN) & drain_last;

endmodule

/* rtl/cam_mbist_inhandler.sv */
// CAM BIST input handler: background inversion, rotating mask, compare data and port select
`timescale 1ns/100ps

module cam_mbist_inhandler
   import cam_array_pkg::*;
   import cam_mbist_pkg::*;
(
   input  logic        bist_clk,
   input  logic        rst_b,
   cam_bist_if.handler bist,
   input  logic        scan_mode,
   // Functional request, accepted when not busy
   input  logic        func_valid,
   input  logic        func_write,
   input  cam_addr_t   func_addr,
   input  cam_data_t   func_data,
   // Array port
   output logic        arr_wr_en,
   output cam_addr_t   arr_wr_addr,
   output cam_data_t   arr_wr_data,
   output logic        arr_srch_en,
   output cam_data_t   arr_srch_data
);

   cam_data_t mask_q;
   cam_data_t bist_wr_data;
   cam_data_t bist_cmp_data;

   //--------------------------------------------------------------------------
   // Rotating mask
   //--------------------------------------------------------------------------

   // One-hot, starts on bit 0 and moves towards the MSB
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         mask_q <= cam_data_t'(1);
      end else if (bist.rotate_mask) begin
         mask_q <= {mask_q[CAM_WIDTH-2:0], mask_q[CAM_WIDTH-1]};
      end else if (scan_mode) begin
         // Scan access through the functional key
         mask_q <= func_data;
      end
   end

   //--------------------------------------------------------------------------
   // Data generation
   //--------------------------------------------------------------------------

   // Pattern or its complement
   assign bist_wr_data  = BIST_BACKGROUND ^ {CAM_WIDTH{bist.data_inv}};

   // Masked bit flipped for miss searches, plain background for the hit search
   assign bist_cmp_data = ({CAM_WIDTH{bist.cd_mask_enable}} & mask_q) ^ bist_wr_data;

   assign arr_srch_data = bist.cm_mode ? bist_cmp_data : func_data;

   //--------------------------------------------------------------------------
   // Port select
   //--------------------------------------------------------------------------

   always_comb begin
      if (bist.busy) begin
         arr_wr_en   = bist.wr_en;
         arr_wr_addr = bist.wr_addr;
         arr_wr_data = bist_wr_data;
         arr_srch_en = bist.srch_en;
      end else begin
         // func_write picks write, else search
         arr_wr_en   = func_valid & func_write;
         arr_wr_addr = func_addr;
         arr_wr_data = func_data;
         arr_srch_en = func_valid & ~func_write;
      end
   end

endmodule

/* rtl/cam_array.sv */
// Behavioural binary CAM with one write port and a registered parallel search
`timescale 1ns/100ps

module cam_array
   import cam_array_pkg::*;
(
   input  logic       bist_clk,
   input  logic       rst_b,
   // Write port
   input  logic       wr_en,
   input  cam_addr_t  wr_addr,
   input  cam_data_t  wr_data,
   // Search port
   input  logic       srch_en,
   input  cam_data_t  srch_data,
   output logic       match_valid,
   output cam_match_t match_vec
);

   cam_data_t  entry_mem [CAM_DEPTH];
   cam_match_t hit_vec;

   //--------------------------------------------------------------------------
   // Storage
   //--------------------------------------------------------------------------

   always_ff @(posedge bist_clk) begin
      if (wr_en) begin
         entry_mem[wr_addr] <= wr_data;
      end
   end

   //--------------------------------------------------------------------------
   // Search
   //--------------------------------------------------------------------------

   // All entries against the key at once
   always_comb begin
      for (int i = 0; i < CAM_DEPTH; i++) begin
         hit_vec[i] = (entry_mem[i] == srch_data);
      end
   end

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         match_valid <= 1'b0;
      end else begin
         match_valid <= srch_en;
      end
   end

   // Result held until the next search
   always_ff @(posedge bist_clk) begin
      if (srch_en) begin
         match_vec <= hit_vec;
      end
   end

endmodule

/* rtl/cam_mbist_resp.sv */
// CAM BIST response checker: compares search results and keeps a sticky fail
`timescale 1ns/100ps

module cam_mbist_resp
   import cam_array_pkg::*;
(
   input  logic       bist_clk,
   input  logic       rst_b,
   input  logic       chk_clear,
   // Qualification from the controller, one cycle ahead of the result
   input  logic       chk_en,
   input  logic       exp_hit,
   // Result from the array
   input  logic       match_valid,
   input  cam_match_t match_vec,
   output logic       bist_fail,
   output cam_match_t bist_fail_match
);

   logic       chk_en_q;
   logic       exp_hit_q;
   cam_match_t exp_vec;
   logic       mismatch;

   // Hit search expects every entry, miss search expects none
   assign exp_vec  = exp_hit_q ? '1 : '0;

   // A missing result counts as a failure too
   assign mismatch = chk_en_q & (~match_valid | (match_vec != exp_vec));

   //--------------------------------------------------------------------------
   // Alignment with the array latency
   //--------------------------------------------------------------------------

   always_ff @(posedge bist_clk) begin
      if (!rst_b || chk_clear) begin
         chk_en_q  <= 1'b0;
         exp_hit_q <= 1'b0;
      end else begin
         chk_en_q  <= chk_en;
         exp_hit_q <= exp_hit;
      end
   end

   //--------------------------------------------------------------------------
   // Sticky fail
   //--------------------------------------------------------------------------

   always_ff @(posedge bist_clk) begin
      if (!rst_b || chk_clear) begin
         bist_fail       <= 1'b0;
         bist_fail_match <= '0;
      end else if (mismatch && !bist_fail) begin
         // First failing vector only
         bist_fail       <= 1'b1;
         bist_fail_match <= match_vec;
      end
   end

endmodule

/* rtl/cam_mbist_top.sv */
// CAM with BIST top level: controller, input handler, array and checker
`timescale 1ns/100ps

module cam_mbist_top
   import cam_array_pkg::*;
(
   input  logic       bist_clk,
   input  logic       rst_b,
   input  logic       scan_mode,
   // BIST start and status
   input  logic       bist_start_valid,
   output logic       bist_start_ready,
   output logic       bist_done,
   output logic       bist_fail,
   output cam_match_t bist_fail_match,
   // Functional port
   input  logic       func_valid,
   output logic       func_ready,
   input  logic       func_write,
   input  cam_addr_t  func_addr,
   input  cam_data_t  func_data,
   // Search result
   output logic       match_valid,
   output cam_match_t match_vec
);

   logic      arr_wr_en;
   cam_addr_t arr_wr_addr;
   cam_data_t arr_wr_data;
   logic      arr_srch_en;
   cam_data_t arr_srch_data;
   logic      chk_en;
   logic      exp_hit;
   logic      chk_clear;

   // Controller to handler commands
   cam_bist_if bist_if ();

   //--------------------------------------------------------------------------
   // BIST control
   //--------------------------------------------------------------------------

   cam_mbist_ctrl cam_mbist_ctrl_inst (
      .bist_clk         (bist_clk),
      .rst_b            (rst_b),
      .bist_start_valid (bist_start_valid),
      .bist_start_ready (bist_start_ready),
      .bist_done        (bist_done),
      .bist             (bist_if.ctrl),
      .func_ready       (func_ready),
      .chk_en           (chk_en),
      .exp_hit          (exp_hit),
      .chk_clear        (chk_clear)
   );

   cam_mbist_inhandler cam_mbist_inhandler_inst (
      .bist_clk      (bist_clk),
      .rst_b         (rst_b),
      .bist          (bist_if.handler),
      .scan_mode     (scan_mode),
      .func_valid    (func_valid),
      .func_write    (func_write),
      .func_addr     (func_addr),
      .func_data     (func_data),
      .arr_wr_en     (arr_wr_en),
      .arr_wr_addr   (arr_wr_addr),
      .arr_wr_data   (arr_wr_data),
      .arr_srch_en   (arr_srch_en),
      .arr_srch_data (arr_srch_data)
   );

   //--------------------------------------------------------------------------
   // Array and checker
   //--------------------------------------------------------------------------

   cam_array cam_array_inst (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .wr_en       (arr_wr_en),
      .wr_addr     (arr_wr_addr),
      .wr_data     (arr_wr_data),
      .srch_en     (arr_srch_en),
      .srch_data   (arr_srch_data),
      .match_valid (match_valid),
      .match_vec   (match_vec)
   );

   cam_mbist_resp cam_mbist_resp_inst (
      .bist_clk        (bist_clk),
      .rst_b           (rst_b),
      .chk_clear       (chk_clear),
      .chk_en          (chk_en),
      .exp_hit         (exp_hit),
      .match_valid     (match_valid),
      .match_vec       (match_vec),
      .bist_fail       (bist_fail),
      .bist_fail_match (bist_fail_match)
   );

endmodule

/* dv/cam_mbist_tb.sv */
// Testbench for the CAM BIST with functional access, march and scan-mode mask corruption
`timescale 1ns/100ps

module cam_mbist_tb
   import cam_array_pkg::*;
();

   localparam int        CLK_PERIOD   = 8;
   localparam int        RESET_CYCLES = 10;
   localparam int        DRIVE_DELAY  = 1;
   localparam bit [31:0] RAND_SEED    = 32'h06a3_3cde;
   // Base data background of the march
   localparam cam_data_t BG_PATTERN   = 16'h5A3C;
   // Writes, one hit search and one miss search per bit in each of two backgrounds plus drain
   localparam int        MARCH_CYCLES = 2 * (CAM_DEPTH + 1 + CAM_WIDTH) + 2;
   localparam int        NUM_KEYS     = 12;
   localparam int        DONE_TIMEOUT = MARCH_CYCLES + 10;
   // Reset, functional traffic, two march runs and slack
   localparam int        WATCHDOG_CYCLES = RESET_CYCLES + 2 * (CAM_DEPTH + NUM_KEYS + 4)
                                         + 2 * (DONE_TIMEOUT + 4) + 50;

   logic       bist_clk;
   logic       rst_b;
   logic       scan_mode;
   logic       bist_start_valid;
   logic       bist_start_ready;
   logic       bist_done;
   logic       bist_fail;
   cam_match_t bist_fail_match;
   logic       func_valid;
   logic       func_ready;
   logic       func_write;
   cam_addr_t  func_addr;
   cam_data_t  func_data;
   logic       match_valid;
   cam_match_t match_vec;

   string      test_name;
   int         errors;
   int         errors_at_start;
   int         tests_run;
   int         tests_failed;
   int         march_cycles;
   cam_data_t  key;
   // High from the start handshake up to the edge that ends the march
   bit         march_active;
   // Reference copy of the CAM contents
   cam_data_t  model_mem [CAM_DEPTH];

   cam_mbist_top cam_mbist_top_inst (
      .bist_clk         (bist_clk),
      .rst_b            (rst_b),
      .scan_mode        (scan_mode),
      .bist_start_valid (bist_start_valid),
      .bist_start_ready (bist_start_ready),
      .bist_done        (bist_done),
      .bist_fail        (bist_fail),
      .bist_fail_match  (bist_fail_match),
      .func_valid       (func_valid),
      .func_ready       (func_ready),
      .func_write       (func_write),
      .func_addr        (func_addr),
      .func_data        (func_data),
      .match_valid      (match_valid),
      .match_vec        (match_vec)
   );

   initial bist_clk = 1'b0;
   always #(CLK_PERIOD / 2) bist_clk = ~bist_clk;

   //--------------------------------------------------------------------------
   // Protocol properties
   //--------------------------------------------------------------------------

   // Both ports closed for exactly the length of a march
   ready_follows_march: assert property (@(posedge bist_clk) disable iff (!rst_b)
                                         (func_ready == !march_active) &&
                                         (bist_start_ready == !march_active))
   else begin
      $display("ready signals do not follow the BIST run at %0t", $time);
      errors++;
   end

   // Done only ever pulses inside a march
   done_in_march: assert property (@(posedge bist_clk) disable iff (!rst_b)
                                   bist_done |-> march_active)
   else begin
      $display("bist_done pulsed outside a BIST run at %0t", $time);
      errors++;
   end

   // Hang guard
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

   //--------------------------------------------------------------------------
   // Helpers
   //--------------------------------------------------------------------------

   // Next rising edge plus the drive delay
   task automatic step();
      @(posedge bist_clk);
      #DRIVE_DELAY;
   endtask

   task automatic check_eq(input string what, input logic [15:0] exp, input logic [15:0] act);
      assert (act === exp)
      else begin
         $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = errors;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors != errors_at_start) begin
         tests_failed++;
         $display("test %0d %s: FAIL, %0d errors", tests_run, test_name, errors - errors_at_start);
      end else begin
         $display("test %0d %s: pass", tests_run, test_name);
      end
   endtask

   // Expected match vector with one bit per model entry equal to the key
   function automatic cam_match_t match_model(input cam_data_t k);
      cam_match_t vec;
      for (int i = 0; i < CAM_DEPTH; i++) begin
         vec[i] = (model_mem[i] == k);
      end
      return vec;
   endfunction

   // One functional transfer that returns one cycle after the accepting edge
   task automatic func_transfer(input logic write, input cam_addr_t addr, input cam_data_t data);
      int waited;
      func_valid = 1'b1;
      func_write = write;
      func_addr  = addr;
      func_data  = data;
      waited     = 0;
      while (!func_ready && waited < DONE_TIMEOUT) begin
         step();
         waited++;
      end
      if (!func_ready) begin
         $display("%s: functional port never became ready", test_name);
         errors++;
      end
      step();
      func_valid = 1'b0;
   endtask

   task automatic search_check(input cam_data_t k, input cam_match_t exp);
      func_transfer(1'b0, '0, k);
      check_eq("match_valid", 16'h0001, 16'(match_valid));
      check_eq("match_vec", exp, match_vec);
   endtask

   // Start handshake and cycle count up to bist_done
   task automatic run_march(input bit hold_func, input bit expect_pass, output int cycles);
      bit done;
      check_eq("bist_start_ready", 16'h0001, 16'(bist_start_ready));
      bist_start_valid = 1'b1;
      step();
      bist_start_valid = 1'b0;
      march_active     = 1'b1;
      if (hold_func) begin
         // A write that must wait until BIST is over
         func_valid = 1'b1;
         func_write = 1'b1;
         func_addr  = '0;
         func_data  = 16'hFFFF;
      end
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < DONE_TIMEOUT) begin
         @(negedge bist_clk);
         cycles++;
         check_eq("func_ready", 16'h0000, 16'(func_ready));
         if (expect_pass) begin
            check_eq("bist_fail", 16'h0000, 16'(bist_fail));
         end
         done = bist_done;
      end
      // Withdrawn before the port reopens
      step();
      func_valid   = 1'b0;
      march_active = 1'b0;
      if (!done) begin
         $display("%s: bist_done did not arrive within %0d cycles", test_name, DONE_TIMEOUT);
         errors++;
      end
   endtask

   //--------------------------------------------------------------------------
   // Test sequence
   //--------------------------------------------------------------------------

   initial begin
      rst_b            = 1'b0;
      scan_mode        = 1'b0;
      bist_start_valid = 1'b0;
      func_valid       = 1'b0;
      func_write       = 1'b0;
      func_addr        = '0;
      func_data        = '0;
      march_active     = 1'b0;
      errors           = 0;
      tests_run        = 0;
      tests_failed     = 0;
      void'($urandom(RAND_SEED));

      repeat (RESET_CYCLES) @(posedge bist_clk);
      #DRIVE_DELAY;
      rst_b = 1'b1;

      start_test("reset_state");
      check_eq("func_ready", 16'h0001, 16'(func_ready));
      check_eq("bist_start_ready", 16'h0001, 16'(bist_start_ready));
      check_eq("bist_done", 16'h0000, 16'(bist_done));
      check_eq("bist_fail", 16'h0000, 16'(bist_fail));
      finish_test();

      // Few distinct values so that keys hit several entries
      start_test("func_write_search");
      for (int i = 0; i < CAM_DEPTH; i++) begin
         model_mem[i] = 16'(($urandom % 6) * 16'h1111);
         func_transfer(1'b1, cam_addr_t'(i), model_mem[i]);
      end
      for (int k = 0; k < NUM_KEYS; k++) begin
         // Value 6 is never stored so some keys miss
         key = 16'(($urandom % 7) * 16'h1111);
         search_check(key, match_model(key));
      end
      finish_test();

      start_test("bist_good_array");
      run_march(1'b1, 1'b1, march_cycles);
      check_eq("done latency", 16'(MARCH_CYCLES), 16'(march_cycles));
      check_eq("bist_fail", 16'h0000, 16'(bist_fail));
      finish_test();

      // Second background is the complement of the pattern
      start_test("contents_after_bist");
      for (int i = 0; i < CAM_DEPTH; i++) begin
         model_mem[i] = ~BG_PATTERN;
      end
      search_check(~BG_PATTERN, '1);
      search_check(BG_PATTERN, '0);
      search_check(16'hFFFF, match_model(16'hFFFF));
      finish_test();

      // Zero mask turns every miss search into a full hit
      start_test("scan_mask_corrupt");
      scan_mode = 1'b1;
      func_data = '0;
      step();
      step();
      run_march(1'b0, 1'b0, march_cycles);
      check_eq("bist_fail", 16'h0001, 16'(bist_fail));
      check_eq("bist_fail_match", 16'hFFFF, bist_fail_match);
      scan_mode = 1'b0;
      finish_test();

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* tb.f */
rtl/cam_array_pkg.sv
rtl/cam_mbist_pkg.sv
rtl/cam_bist_if.sv
rtl/cam_mbist_ctrl.sv
rtl/cam_mbist_inhandler.sv
rtl/cam_array.sv
rtl/cam_mbist_resp.sv
rtl/cam_mbist_top.sv
dv/cam_mbist_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CAM BIST testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cam_mbist_tb -f tb.f -o cam_mbist_sim \
   && ./obj_dir/cam_mbist_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
